//--- Makefile
# Verilator build and run for the RV32I hart testbench

TOP             ?= tb_hart
FILELIST        ?= compile.f
SEED_LOG        ?= sim.log
OBJ_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert

FAIL_MSG := FAIL: see errors above
PASS_MSG := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, the simulator exit code is only recorded
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(SEED_LOG) 2>&1
	@cat $(SEED_LOG)
	@if grep -q "$(FAIL_MSG)" $(SEED_LOG); then echo "simulation reported errors"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(SEED_LOG); then echo "simulation ended without passing"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(SEED_LOG)

//--- compile.f
hdl/hart_pkg.sv
hdl/reg_file.sv
hdl/hart_decode.sv
hdl/hart_execute.sv
hdl/hart_result.sv
hdl/hart_top.sv
dv/hart_asserts.sv
dv/tb_hart.sv

//--- dv/hart_asserts.sv
`timescale 1ns/1ps

module hart_asserts (
  input logic i_clk,
  input logic i_rst,
  input logic i_dmem_ren,
  input logic i_dmem_wen,
  input logic i_retire_valid,
  input logic i_halted,  // the hart's halted flag
  input logic i_rf_wen   // write enable as it reaches the register file
);

  // the data port reads or writes in a cycle but never does both
  a_ren_wen_exclusive: assert property (@(posedge i_clk) !(i_dmem_ren && i_dmem_wen))
    else $error("data port read and write enables high together");

  a_quiet_when_halted: assert property (@(posedge i_clk) disable iff (i_rst)
    i_halted |-> (!i_retire_valid && !i_dmem_ren && !i_dmem_wen && !i_rf_wen))
    else $error("retire, memory access or register write while halted");

  a_no_retire_in_reset: assert property (@(posedge i_clk) i_rst |-> !i_retire_valid)
    else $error("retire valid high during reset");

endmodule

bind hart_top hart_asserts u_asserts (
  .i_clk          (i_clk),
  .i_rst          (i_rst),
  .i_dmem_ren     (o_dmem_ren),
  .i_dmem_wen     (o_dmem_wen),
  .i_retire_valid (o_retire_valid),
  .i_halted       (halted_q),
  .i_rf_wen       (u_decode.i_wb_en)
);

//--- dv/tb_hart.sv
`timescale 1ns/1ps

module tb_hart import hart_pkg::*; ();

  localparam int CLK_PERIOD    = 100;
  localparam int DRIVE_DELAY   = 5;              // inputs move this long after the rising edge
  localparam int RESET_CYCLES  = 5;
  localparam int MEM_WORDS     = 256;
  localparam int MAX_RETIRE    = 2000;           // ebreak is forced onto the fetch port after this
  localparam int START_TIMEOUT = 10;
  localparam int HALT_TIMEOUT  = MAX_RETIRE + 100;
  localparam int QUIET_CYCLES  = 20;

  logic       clk;
  logic       rst;
  word_t      imem_raddr;
  word_t      imem_rdata;
  word_t      dmem_addr;
  logic       dmem_ren;
  logic       dmem_wen;
  word_t      dmem_wdata;
  byte_mask_t dmem_mask;
  word_t      dmem_rdata;
  logic       retire_valid;
  logic       retire_halt;
  word_t      retire_inst;
  reg_addr_t  retire_rs1_raddr;
  reg_addr_t  retire_rs2_raddr;
  reg_addr_t  retire_rd_waddr;
  word_t      retire_rs1_rdata;
  word_t      retire_rs2_rdata;
  word_t      retire_rd_wdata;
  word_t      retire_pc;
  word_t      retire_next_pc;

  word_t      imem [0:MEM_WORDS-1];    // program seen by the DUT
  word_t      dmem [0:MEM_WORDS-1];    // data memory seen by the DUT
  word_t      ref_mem [0:MEM_WORDS-1]; // the reference model keeps its own copy
  word_t      ref_regs [0:31];
  word_t      ref_pc;
  word_t      halt_pc;
  logic       model_halted;
  logic       force_ebreak;            // replaces the fetched word once the retire budget is spent
  integer     seed;
  int         retire_count;
  int         wait_cycles;
  logic       wr_pend;                 // store captured at the falling edge, written at the next rising edge
  word_t      wr_addr;
  word_t      wr_data;
  byte_mask_t wr_mask;

  hart_top #(.RESET_ADDR(32'h0000_0000)) uut (
    .i_clk              (clk),
    .i_rst              (rst),
    .o_imem_raddr       (imem_raddr),
    .i_imem_rdata       (imem_rdata),
    .o_dmem_addr        (dmem_addr),
    .o_dmem_ren         (dmem_ren),
    .o_dmem_wen         (dmem_wen),
    .o_dmem_wdata       (dmem_wdata),
    .o_dmem_mask        (dmem_mask),
    .i_dmem_rdata       (dmem_rdata),
    .o_retire_valid     (retire_valid),
    .o_retire_halt      (retire_halt),
    .o_retire_inst      (retire_inst),
    .o_retire_rs1_raddr (retire_rs1_raddr),
    .o_retire_rs2_raddr (retire_rs2_raddr),
    .o_retire_rd_waddr  (retire_rd_waddr),
    .o_retire_rs1_rdata (retire_rs1_rdata),
    .o_retire_rs2_rdata (retire_rs2_rdata),
    .o_retire_rd_wdata  (retire_rd_wdata),
    .o_retire_pc        (retire_pc),
    .o_retire_next_pc   (retire_next_pc)
  );

  // both memories answer in the same cycle and wrap modulo their size
  assign imem_rdata = force_ebreak ? EBREAK_WORD : imem[imem_raddr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // the fill value depends on every bit of the word index
  function automatic word_t fill_word(input int idx);
    logic [7:0] a;
    a = idx[7:0];
    return {a, ~a, a ^ 8'h5a, a + 8'h81};
  endfunction

  function automatic word_t lane_bits(input byte_mask_t m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  always @(negedge clk) begin
    wr_pend <= dmem_wen;
    wr_addr <= dmem_addr;
    wr_data <= dmem_wdata;
    wr_mask <= dmem_mask;
  end

  // memory is refilled while reset is held, otherwise only masked lanes are written
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        dmem[i] <= fill_word(i);
      end
    end else if (wr_pend) begin
      for (int b = 0; b < 4; b++) begin
        if (wr_mask[b]) begin
          dmem[wr_addr[9:2]][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

  // one random instruction that keeps jumps word aligned and memory accesses size aligned
  function automatic word_t random_inst();
    word_t       r;
    int          kind;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [2:0]  f3;
    logic [11:0] imm12;
    logic [12:0] boff;
    logic [20:0] joff;
    word_t       inst;
    r    = $random(seed);
    kind = $unsigned($random(seed)) % 11;
    rd   = r[11:7];
    rs1  = r[19:15];
    rs2  = r[24:20];
    f3   = r[14:12];
    case (kind)
      0: begin
        inst = {((f3 == 3'b000 || f3 == 3'b101) && r[30]) ? 7'b0100000 : 7'b0000000,
                rs2, rs1, f3, rd, OP_REG};
      end
      1, 2: begin
        if (f3 == 3'b001) begin
          imm12 = {7'b0, r[24:20]};            // slli keeps the upper bits clear
        end else if (f3 == 3'b101) begin
          imm12 = {1'b0, r[30], 5'b0, r[24:20]}; // bit 30 picks srai
        end else begin
          imm12 = r[31:20];
        end
        inst = {imm12, rs1, f3, rd, OP_IMM};
      end
      3: inst = {r[31:12], rd, OP_LUI};
      4: inst = {r[31:12], rd, OP_AUIPC};
      5: begin
        if (f3[2:1] == 2'b01) f3[2] = 1'b1;  // funct3 010 and 011 are not branches
        boff = {{6{r[29]}}, r[29:25], 2'b00}; // -64 to +60 bytes
        if (r[29:25] == 5'd0) boff = 13'd4;
        inst = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], OP_BRANCH};
      end
      6: begin
        joff = {{14{r[29]}}, r[29:25], 2'b00};
        if (r[29:25] == 5'd0) joff = 21'd4;
        inst = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OP_JAL};
      end
      7: inst = {2'b00, r[29:22], 2'b00, 5'd0, 3'b000, rd, OP_JALR}; // base x0
      8: begin
        if (f3[1:0] == 2'b11) begin
          f3 = 3'b010;
        end else if (f3 == 3'b110) begin
          f3 = 3'b100;
        end
        imm12 = {{6{r[31]}}, r[30:25]};      // small window so loads meet earlier stores
        imm12 = (imm12 >> f3[1:0]) << f3[1:0];
        inst  = {imm12, 5'd0, f3, rd, OP_LOAD};
      end
      9: begin
        f3    = {1'b0, (f3[1:0] == 2'b11) ? 2'b10 : f3[1:0]};
        imm12 = {{6{r[31]}}, r[30:25]};
        imm12 = (imm12 >> f3[1:0]) << f3[1:0];
        inst  = {imm12[11:5], rs2, 5'd0, f3, imm12[4:0], OP_STORE};
      end
      default: inst = 32'h0ff0_000f; // fence, a no-op here
    endcase
    return inst;
  endfunction

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    word_t res;
    case (f3)
      3'b000:  res = alt ? a - b : a + b;
      3'b001:  res = a << b[4:0];
      3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  res = (a < b) ? 32'd1 : 32'd0;
      3'b100:  res = a ^ b;
      3'b101:  res = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t exp_val, input word_t act_val);
    if (act_val !== exp_val) begin
      $display("FAILED time %0d ns: %s expected 0x%08h actual 0x%08h",
               $time, name, exp_val, act_val);
      stop_run();
    end
  endtask

  task automatic check_reg_addr(input string name, input reg_addr_t exp_val,
                                input reg_addr_t act_val);
    if (act_val !== exp_val) begin
      $display("FAILED time %0d ns: %s expected x%0d actual x%0d", $time, name, exp_val, act_val);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      $display("FAILED time %0d ns: %s expected %b actual %b", $time, name, exp_val, act_val);
      stop_run();
    end
  endtask

  task automatic check_mask(input string name, input byte_mask_t exp_val,
                            input byte_mask_t act_val);
    if (act_val !== exp_val) begin
      $display("FAILED time %0d ns: %s expected %b actual %b", $time, name, exp_val, act_val);
      stop_run();
    end
  endtask

  // executes the instruction at the model pc and compares every retire field
  task automatic model_step();
    word_t      inst;
    word_t      rs1v;
    word_t      rs2v;
    word_t      wdata;
    word_t      next_pc;
    word_t      addr;
    word_t      lword;
    word_t      sdata;
    word_t      iimm;
    word_t      simm;
    word_t      bimm;
    word_t      jimm;
    word_t      uimm;
    logic [6:0] opc;
    logic [2:0] f3;
    reg_addr_t  rs1a;
    reg_addr_t  rs2a;
    reg_addr_t  rda;
    logic       use1;
    logic       use2;
    logic       writes;
    logic       is_load;
    logic       is_store;
    byte_mask_t mask;
    inst = force_ebreak ? EBREAK_WORD : imem[ref_pc[9:2]];
    opc  = inst[6:0];
    f3   = inst[14:12];
    iimm = {{20{inst[31]}}, inst[31:20]};
    simm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    bimm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    jimm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    uimm = {inst[31:12], 12'b0};
    use1 = (opc == OP_JALR) || (opc == OP_LOAD) || (opc == OP_IMM) ||
           (opc == OP_BRANCH) || (opc == OP_STORE) || (opc == OP_REG);
    use2 = (opc == OP_BRANCH) || (opc == OP_STORE) || (opc == OP_REG);
    rs1a = use1 ? inst[19:15] : 5'd0; // absent sources report x0
    rs2a = use2 ? inst[24:20] : 5'd0;
    rs1v = ref_regs[rs1a];
    rs2v = ref_regs[rs2a];
    next_pc  = ref_pc + 32'd4;
    wdata    = '0;
    writes   = 1'b0;
    is_load  = 1'b0;
    is_store = 1'b0;
    addr     = '0;
    mask     = '0;
    sdata    = '0;
    case (opc)
      OP_LUI: begin
        writes = 1'b1;
        wdata  = uimm;
      end
      OP_AUIPC: begin
        writes = 1'b1;
        wdata  = ref_pc + uimm;
      end
      OP_JAL: begin
        writes  = 1'b1;
        wdata   = ref_pc + 32'd4;
        next_pc = ref_pc + jimm;
      end
      OP_JALR: begin
        writes  = 1'b1;
        wdata   = ref_pc + 32'd4;
        next_pc = (rs1v + iimm) & 32'hffff_fffe;
      end
      OP_BRANCH: begin
        if (branch_ref(f3, rs1v, rs2v)) next_pc = ref_pc + bimm;
      end
      OP_LOAD: begin
        writes  = 1'b1;
        is_load = 1'b1;
        addr    = rs1v + iimm;
        lword   = ref_mem[addr[9:2]] >> {addr[1:0], 3'b000}; // addressed bytes down to bit 0
        case (f3)
          3'b000:  wdata = {{24{lword[7]}}, lword[7:0]};
          3'b001:  wdata = {{16{lword[15]}}, lword[15:0]};
          3'b100:  wdata = {24'b0, lword[7:0]};
          3'b101:  wdata = {16'b0, lword[15:0]};
          default: wdata = lword;
        endcase
      end
      OP_STORE: begin
        is_store = 1'b1;
        addr     = rs1v + simm;
        case (f3[1:0])
          2'b00:   mask = 4'b0001 << addr[1:0];
          2'b01:   mask = 4'b0011 << addr[1:0];
          default: mask = 4'b1111;
        endcase
        sdata = rs2v << {addr[1:0], 3'b000};
      end
      OP_IMM: begin
        writes = 1'b1;
        wdata  = alu_ref(f3, inst[30] && (f3 == 3'b101), rs1v, iimm); // addi has no sub form
      end
      OP_REG: begin
        writes = 1'b1;
        wdata  = alu_ref(f3, inst[30], rs1v, rs2v);
      end
      default: ; // fence and system words change nothing
    endcase
    rda = writes ? inst[11:7] : 5'd0;
    check_word("o_retire_pc", ref_pc, retire_pc);
    check_word("o_retire_inst", inst, retire_inst);
    check_flag("o_retire_halt", inst == EBREAK_WORD, retire_halt);
    check_reg_addr("o_retire_rs1_raddr", rs1a, retire_rs1_raddr);
    check_reg_addr("o_retire_rs2_raddr", rs2a, retire_rs2_raddr);
    check_word("o_retire_rs1_rdata", rs1v, retire_rs1_rdata);
    check_word("o_retire_rs2_rdata", rs2v, retire_rs2_rdata);
    check_reg_addr("o_retire_rd_waddr", rda, retire_rd_waddr);
    if (rda != 5'd0) check_word("o_retire_rd_wdata", wdata, retire_rd_wdata);
    check_word("o_retire_next_pc", next_pc, retire_next_pc);
    check_flag("o_dmem_ren", is_load, dmem_ren);
    check_flag("o_dmem_wen", is_store, dmem_wen);
    if (is_load || is_store) check_word("o_dmem_addr", {addr[31:2], 2'b00}, dmem_addr);
    if (is_store) begin
      check_mask("o_dmem_mask", mask, dmem_mask);
      // only the enabled lanes carry meaning on the write bus
      check_word("o_dmem_wdata", sdata & lane_bits(mask), dmem_wdata & lane_bits(mask));
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) ref_mem[addr[9:2]][8*b +: 8] = sdata[8*b +: 8];
      end
    end
    if (rda != 5'd0) ref_regs[rda] = wdata;
    if (inst == EBREAK_WORD) begin
      model_halted = 1'b1;
      halt_pc      = ref_pc; // the pc freezes on the ebreak itself
    end else begin
      ref_pc = next_pc;
    end
  endtask

  initial begin
    rst          = 1'b1;
    force_ebreak = 1'b0;
    model_halted = 1'b0;
    retire_count = 0;
    halt_pc      = '0;
    seed         = 46919;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i]    = random_inst();
      ref_mem[i] = fill_word(i);
    end
    imem[MEM_WORDS-1] = EBREAK_WORD; // the last word always stops the hart
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    ref_pc = 32'h0000_0000;

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    wait_cycles = 0;
    @(negedge clk);
    while (!retire_valid) begin
      wait_cycles++;
      if (wait_cycles > START_TIMEOUT) begin
        $display("timeout: no instruction retired within %0d cycles of reset", START_TIMEOUT);
        stop_run();
      end
      @(negedge clk);
    end
    check_word("o_retire_pc on first retire", 32'h0000_0000, retire_pc);

    // single cycle hart, so every running cycle retires exactly one instruction
    wait_cycles = 0;
    while (!model_halted) begin
      check_flag("o_retire_valid", 1'b1, retire_valid);
      model_step();
      retire_count++;
      wait_cycles++;
      if (wait_cycles > HALT_TIMEOUT) begin
        $display("timeout: the hart did not halt within %0d cycles", HALT_TIMEOUT);
        stop_run();
      end
      @(posedge clk);
      #DRIVE_DELAY;
      if (retire_count >= MAX_RETIRE) force_ebreak = 1'b1;
      @(negedge clk);
    end

    repeat (QUIET_CYCLES) begin
      check_flag("o_retire_valid after halt", 1'b0, retire_valid);
      check_flag("o_dmem_ren after halt", 1'b0, dmem_ren);
      check_flag("o_dmem_wen after halt", 1'b0, dmem_wen);
      check_word("o_imem_raddr after halt", halt_pc, imem_raddr);
      @(negedge clk);
    end

    $display("retired %0d instructions", retire_count);
    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- hdl/hart_decode.sv
`timescale 1ns/1ps

module hart_decode import hart_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst,
  input  word_t i_inst,
  input  logic  i_wb_en,   // write enable of the retiring instruction, already gated by the top
  input  word_t i_wb_data,
  output ctrl_t o_ctrl,
  output word_t o_rs1_data,
  output word_t o_rs2_data
);

  logic [2:0] funct3;
  logic       funct7_alt; // bit 30 picks sub and sra
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  // maps funct3 onto an ALU op, the alt bit only means sub for register forms
  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt,
                                              input logic is_reg);
    alu_op_e op;
    case (f3)
      3'b000: op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
      3'b001: op = ALU_SLL;
      3'b010: op = ALU_SLT;
      3'b011: op = ALU_SLTU;
      3'b100: op = ALU_XOR;
      3'b101: op = alt ? ALU_SRA : ALU_SRL; // srai also carries bit 30
      3'b110: op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign funct3     = i_inst[14:12];
  assign funct7_alt = i_inst[30];

  // the five immediate formats, all sign extended from bit 31 except U
  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'b0};
  assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_ctrl = '0; // a do-nothing instruction, alu add and wb from alu
    case (opcode_e'(i_inst[6:0]))
      OP_LUI: begin
        o_ctrl.alu_op    = ALU_PASS_B; // rd gets the U immediate as it is
        o_ctrl.op_b_imm  = 1'b1;
        o_ctrl.reg_write = 1'b1;
        o_ctrl.imm       = imm_u;
      end
      OP_AUIPC: begin
        o_ctrl.op_a_pc   = 1'b1;
        o_ctrl.op_b_imm  = 1'b1;
        o_ctrl.reg_write = 1'b1;
        o_ctrl.imm       = imm_u;
      end
      OP_JAL: begin
        o_ctrl.jal       = 1'b1; // target is pc plus imm, formed in execute
        o_ctrl.reg_write = 1'b1;
        o_ctrl.wb_sel    = WB_PC4;
        o_ctrl.imm       = imm_j;
      end
      OP_JALR: begin
        o_ctrl.jalr      = 1'b1; // target comes out of the ALU sum rs1 plus imm
        o_ctrl.op_b_imm  = 1'b1;
        o_ctrl.reg_write = 1'b1;
        o_ctrl.wb_sel    = WB_PC4;
        o_ctrl.imm       = imm_i;
      end
      OP_BRANCH: begin
        o_ctrl.branch    = 1'b1;
        o_ctrl.br_funct3 = funct3;
        o_ctrl.imm       = imm_b;
      end
      OP_LOAD: begin
        o_ctrl.op_b_imm      = 1'b1; // address is rs1 plus imm
        o_ctrl.mem_read      = 1'b1;
        o_ctrl.mem_size      = mem_size_e'(funct3[1:0]);
        o_ctrl.load_unsigned = funct3[2];
        o_ctrl.reg_write     = 1'b1;
        o_ctrl.wb_sel        = WB_LOAD;
        o_ctrl.imm           = imm_i;
      end
      OP_STORE: begin
        o_ctrl.op_b_imm  = 1'b1;
        o_ctrl.mem_write = 1'b1;
        o_ctrl.mem_size  = mem_size_e'(funct3[1:0]);
        o_ctrl.imm       = imm_s;
      end
      OP_IMM: begin
        o_ctrl.alu_op    = alu_from_funct3(funct3, funct7_alt, 1'b0);
        o_ctrl.op_b_imm  = 1'b1;
        o_ctrl.reg_write = 1'b1;
        o_ctrl.imm       = imm_i; // shifts only look at the low five bits
      end
      OP_REG: begin
        o_ctrl.alu_op    = alu_from_funct3(funct3, funct7_alt, 1'b1);
        o_ctrl.reg_write = 1'b1;
      end
      OP_MISC_MEM, OP_SYSTEM: begin
        o_ctrl.imm = imm_i; // fence, ecall, csr and ebreak change no state here
      end
      default: begin
        o_ctrl.imm = '0; // unknown opcodes also fall through as no-ops
      end
    endcase
    // rd stays zero unless the instruction really writes
    o_ctrl.rd = o_ctrl.reg_write ? i_inst[11:7] : '0;
  end

  // the write port takes rd from this same decode since the hart is single cycle
  reg_file u_reg_file (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rs1_addr (i_inst[19:15]),
    .i_rs2_addr (i_inst[24:20]),
    .o_rs1_data (o_rs1_data),
    .o_rs2_data (o_rs2_data),
    .i_rd_addr  (o_ctrl.rd),
    .i_rd_wen   (i_wb_en),
    .i_rd_data  (i_wb_data)
  );

endmodule

//--- hdl/hart_execute.sv
`timescale 1ns/1ps

module hart_execute import hart_pkg::*; (
  input  ctrl_t i_ctrl,
  input  word_t i_pc,
  input  word_t i_rs1_data,
  input  word_t i_rs2_data,
  output word_t o_alu_result,
  output word_t o_next_pc,
  output logic  o_taken       // high when the next pc is not pc plus 4
);

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  logic       br_cond;
  logic       br_taken;
  word_t      pc_plus4;
  word_t      pc_target;

  // operand muxes
  assign op_a  = i_ctrl.op_a_pc ? i_pc : i_rs1_data;   // only auipc uses the pc here
  assign op_b  = i_ctrl.op_b_imm ? i_ctrl.imm : i_rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (i_ctrl.alu_op)
      ALU_ADD:    o_alu_result = op_a + op_b;
      ALU_SUB:    o_alu_result = op_a - op_b;
      ALU_SLL:    o_alu_result = op_a << shamt;
      ALU_SLT:    o_alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   o_alu_result = {31'b0, op_a < op_b};
      ALU_XOR:    o_alu_result = op_a ^ op_b;
      ALU_SRL:    o_alu_result = op_a >> shamt;
      ALU_SRA:    o_alu_result = word_t'($signed(op_a) >>> shamt);
      ALU_OR:     o_alu_result = op_a | op_b;
      ALU_AND:    o_alu_result = op_a & op_b;
      ALU_PASS_B: o_alu_result = op_b;
      default:    o_alu_result = '0;
    endcase
  end

  // branch compare works on the raw register values, never on the immediate
  always_comb begin
    case (i_ctrl.br_funct3)
      3'b000:  br_cond = (i_rs1_data == i_rs2_data);                  // beq
      3'b001:  br_cond = (i_rs1_data != i_rs2_data);                  // bne
      3'b100:  br_cond = ($signed(i_rs1_data) < $signed(i_rs2_data));  // blt
      3'b101:  br_cond = ($signed(i_rs1_data) >= $signed(i_rs2_data)); // bge
      3'b110:  br_cond = (i_rs1_data < i_rs2_data);                   // bltu
      3'b111:  br_cond = (i_rs1_data >= i_rs2_data);                  // bgeu
      default: br_cond = 1'b0; // 010 and 011 are not branches
    endcase
  end

  assign br_taken  = i_ctrl.branch & br_cond;
  assign pc_plus4  = i_pc + 32'd4;
  assign pc_target = i_pc + i_ctrl.imm; // shared by taken branches and jal

  // jalr clears bit 0 of the sum, the other redirects use pc plus imm
  always_comb begin
    if (i_ctrl.jalr) begin
      o_next_pc = {o_alu_result[31:1], 1'b0};
    end else if (br_taken || i_ctrl.jal) begin
      o_next_pc = pc_target;
    end else begin
      o_next_pc = pc_plus4;
    end
  end

  assign o_taken = br_taken | i_ctrl.jal | i_ctrl.jalr;

endmodule

//--- hdl/hart_pkg.sv
package hart_pkg;

  // basic vector types, named by what they carry
  typedef logic [31:0] word_t;      // data, address or instruction word
  typedef logic [4:0]  reg_addr_t;  // register index x0 to x31
  typedef logic [3:0]  byte_mask_t; // one bit per byte lane of a data word

  // ebreak is the only system encoding the hart reacts to
  localparam word_t EBREAK_WORD = 32'h0010_0073;

  // major opcodes, bits 6:0 of the instruction
  typedef enum logic [6:0] {
    OP_LUI      = 7'b0110111,
    OP_AUIPC    = 7'b0010111,
    OP_JAL      = 7'b1101111,
    OP_JALR     = 7'b1100111,
    OP_BRANCH   = 7'b1100011,
    OP_LOAD     = 7'b0000011,
    OP_STORE    = 7'b0100011,
    OP_IMM      = 7'b0010011,
    OP_REG      = 7'b0110011,
    OP_MISC_MEM = 7'b0001111, // fence, treated as a no-op
    OP_SYSTEM   = 7'b1110011  // ebreak halts, everything else is a no-op
  } opcode_e;

  // ALU functions, pass-b forwards operand b untouched for lui
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // write-back source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_PC4 // link value for jal and jalr
  } wb_sel_e;

  // access size, same encoding as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    MEM_BYTE = 2'b00,
    MEM_HALF = 2'b01,
    MEM_WORD = 2'b10
  } mem_size_e;

  // everything decode hands to execute and result, 57 bits
  typedef struct packed {
    alu_op_e   alu_op;
    logic      op_a_pc;       // operand a is the pc instead of rs1
    logic      op_b_imm;      // operand b is the immediate instead of rs2
    logic      branch;
    logic      jal;
    logic      jalr;
    logic [2:0] br_funct3;    // branch condition, only meaningful with branch
    logic      mem_read;
    logic      mem_write;
    mem_size_e mem_size;
    logic      load_unsigned; // lbu and lhu
    logic      reg_write;
    wb_sel_e   wb_sel;
    reg_addr_t rd;            // already zero when reg_write is low
    word_t     imm;
  } ctrl_t;

endpackage

//--- hdl/hart_result.sv
`timescale 1ns/1ps

module hart_result import hart_pkg::*; (
  input  ctrl_t      i_ctrl,
  input  word_t      i_alu_result, // the byte address for loads and stores
  input  word_t      i_rs2_data,
  input  word_t      i_pc,
  input  word_t      i_dmem_rdata,
  output word_t      o_dmem_addr,
  output word_t      o_dmem_wdata,
  output logic       o_dmem_ren,
  output logic       o_dmem_wen,
  output byte_mask_t o_dmem_mask,
  output logic       o_wb_en,
  output word_t      o_wb_data
);

  logic [1:0] offset;       // byte position inside the aligned word
  logic [4:0] lane_shift;   // the same position in bits
  word_t      rdata_shifted;
  word_t      load_data;
  word_t      pc_plus4;

  assign offset     = i_alu_result[1:0];
  assign lane_shift = {offset, 3'b000};

  // the port only sees aligned words, the mask tells which lanes count
  assign o_dmem_addr = {i_alu_result[31:2], 2'b00};
  assign o_dmem_ren  = i_ctrl.mem_read;
  assign o_dmem_wen  = i_ctrl.mem_write; // decode never sets both for one instruction

  always_comb begin
    case (i_ctrl.mem_size)
      MEM_BYTE: o_dmem_mask = byte_mask_t'(4'b0001 << offset);
      MEM_HALF: o_dmem_mask = offset[1] ? 4'b1100 : 4'b0011; // halves are 2-byte aligned
      default:  o_dmem_mask = 4'b1111;
    endcase
  end

  // accesses are aligned to their size so one shift places every size in its lane
  assign o_dmem_wdata = i_rs2_data << lane_shift;

  // bring the addressed bytes down to bit 0 before extending
  assign rdata_shifted = i_dmem_rdata >> lane_shift;

  always_comb begin
    case (i_ctrl.mem_size)
      MEM_BYTE: begin
        if (i_ctrl.load_unsigned) begin
          load_data = {24'b0, rdata_shifted[7:0]};                  // lbu
        end else begin
          load_data = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]}; // lb
        end
      end
      MEM_HALF: begin
        if (i_ctrl.load_unsigned) begin
          load_data = {16'b0, rdata_shifted[15:0]};                   // lhu
        end else begin
          load_data = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]}; // lh
        end
      end
      default: begin
        load_data = i_dmem_rdata; // lw, offset is always zero here
      end
    endcase
  end

  assign pc_plus4 = i_pc + 32'd4; // link value for jal and jalr

  // write-back select
  always_comb begin
    case (i_ctrl.wb_sel)
      WB_LOAD: o_wb_data = load_data;
      WB_PC4:  o_wb_data = pc_plus4;
      default: o_wb_data = i_alu_result;
    endcase
  end

  assign o_wb_en = i_ctrl.reg_write; // the top still gates this with reset and halt

endmodule

//--- hdl/hart_top.sv
`timescale 1ns/1ps

module hart_top import hart_pkg::*; #(
  parameter word_t RESET_ADDR = 32'h0000_0000
) (
  input  logic       i_clk,
  input  logic       i_rst,
  output word_t      o_imem_raddr,
  input  word_t      i_imem_rdata,
  output word_t      o_dmem_addr,
  output logic       o_dmem_ren,
  output logic       o_dmem_wen,
  output word_t      o_dmem_wdata,
  output byte_mask_t o_dmem_mask,
  input  word_t      i_dmem_rdata,
  output logic       o_retire_valid,
  output logic       o_retire_halt,
  output word_t      o_retire_inst,
  output reg_addr_t  o_retire_rs1_raddr,
  output reg_addr_t  o_retire_rs2_raddr,
  output reg_addr_t  o_retire_rd_waddr,
  output word_t      o_retire_rs1_rdata,
  output word_t      o_retire_rs2_rdata,
  output word_t      o_retire_rd_wdata,
  output word_t      o_retire_pc,
  output word_t      o_retire_next_pc
);

  word_t pc_q;
  logic  halted_q;
  logic  run;       // an instruction really executes this cycle
  logic  is_ebreak;
  logic  rs1_used;
  logic  rs2_used;
  ctrl_t ctrl;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_result;
  word_t next_pc;
  logic  taken;
  logic  res_ren;
  logic  res_wen;
  logic  res_wb_en;
  word_t wb_data;

  assign o_imem_raddr = pc_q;
  assign run          = ~i_rst & ~halted_q;
  assign is_ebreak    = (i_imem_rdata == EBREAK_WORD);

  // the pc freezes on ebreak and stays there until reset
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q     <= RESET_ADDR;
      halted_q <= 1'b0;
    end else if (run) begin
      halted_q <= is_ebreak;
      if (!is_ebreak) begin
        pc_q <= next_pc;
      end
    end
  end

  hart_decode u_decode (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_inst     (i_imem_rdata),
    .i_wb_en    (res_wb_en & run), // no register writes in reset or after a halt
    .i_wb_data  (wb_data),
    .o_ctrl     (ctrl),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  hart_execute u_execute (
    .i_ctrl       (ctrl),
    .i_pc         (pc_q),
    .i_rs1_data   (rs1_data),
    .i_rs2_data   (rs2_data),
    .o_alu_result (alu_result),
    .o_next_pc    (next_pc),
    .o_taken      (taken)
  );

  hart_result u_result (
    .i_ctrl       (ctrl),
    .i_alu_result (alu_result),
    .i_rs2_data   (rs2_data),
    .i_pc         (pc_q),
    .i_dmem_rdata (i_dmem_rdata),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_ren   (res_ren),
    .o_dmem_wen   (res_wen),
    .o_dmem_mask  (o_dmem_mask),
    .o_wb_en      (res_wb_en),
    .o_wb_data    (wb_data)
  );

  assign o_dmem_ren = res_ren & run;
  assign o_dmem_wen = res_wen & run;

  // which formats carry rs1 and rs2, the retire port reports zero otherwise
  always_comb begin
    rs1_used = 1'b0;
    rs2_used = 1'b0;
    case (opcode_e'(i_imem_rdata[6:0]))
      OP_JALR, OP_LOAD, OP_IMM: rs1_used = 1'b1;
      OP_BRANCH, OP_STORE, OP_REG: begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
      end
      default: ;
    endcase
  end

  assign o_retire_valid     = run;
  assign o_retire_halt      = run & is_ebreak;
  assign o_retire_inst      = i_imem_rdata;
  assign o_retire_rs1_raddr = rs1_used ? i_imem_rdata[19:15] : '0;
  assign o_retire_rs2_raddr = rs2_used ? i_imem_rdata[24:20] : '0;
  assign o_retire_rs1_rdata = rs1_used ? rs1_data : '0;
  assign o_retire_rs2_rdata = rs2_used ? rs2_data : '0;
  assign o_retire_rd_waddr  = ctrl.rd; // decode already zeroes it for non-writers
  assign o_retire_rd_wdata  = wb_data;
  assign o_retire_pc        = pc_q;
  assign o_retire_next_pc   = taken ? next_pc : pc_q + 32'd4; // ebreak reports pc plus 4

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file import hart_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  reg_addr_t i_rs1_addr,
  input  reg_addr_t i_rs2_addr,
  output word_t     o_rs1_data,
  output word_t     o_rs2_data,
  input  reg_addr_t i_rd_addr,
  input  logic      i_rd_wen,
  input  word_t     i_rd_data
);

  // x0 has no storage, only x1 to x31 exist
  word_t regs [1:31];

  // synchronous write, a write aimed at x0 is simply dropped
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && (i_rd_addr != '0)) begin
      regs[i_rd_addr] <= i_rd_data;
    end
  end

  // combinational reads with x0 hardwired to zero
  // the hart reads and writes a register in different cycles so no bypass is needed
  always_comb begin
    if (i_rs1_addr == '0) begin
      o_rs1_data = '0;
    end else begin
      o_rs1_data = regs[i_rs1_addr];
    end
    if (i_rs2_addr == '0) begin
      o_rs2_data = '0;
    end else begin
      o_rs2_data = regs[i_rs2_addr];
    end
  end

endmodule
